// ==== tb.f ====
common/rs_cfg_pkg.sv
common/branch_op_pkg.sv
branch_rs/rs_control.sv
branch_rs/rs_dispatch_bypass.sv
branch_rs/rs_operand_table.sv
branch_rs/rs_payload_table.sv
branch_rs/branch_rs_top.sv
dv/tb_clock_gen.sv
dv/tb_branch_rs.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_branch_rs
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_branch_rs.sv ====
`timescale 1ns/1ps

module tb_branch_rs;

    localparam int depth     = 16;
    localparam int max_steps = 80;

    localparam branch_op_pkg::op_kind_e br    = branch_op_pkg::op_branch;
    localparam branch_op_pkg::op_kind_e jmp   = branch_op_pkg::op_jump;
    localparam branch_op_pkg::br_cond_e c_eq  = branch_op_pkg::beq;
    localparam branch_op_pkg::br_cond_e c_ne  = branch_op_pkg::bne;
    localparam branch_op_pkg::br_cond_e c_lt  = branch_op_pkg::blt;
    localparam branch_op_pkg::br_cond_e c_ge  = branch_op_pkg::bge;
    localparam branch_op_pkg::br_cond_e c_ltu = branch_op_pkg::bltu;
    localparam branch_op_pkg::br_cond_e c_geu = branch_op_pkg::bgeu;

    // one cycle of stimulus, also reused as a model entry and an issue record
    typedef struct packed {
        logic                    disp;
        rs_cfg_pkg::data_t       inst;
        rs_cfg_pkg::data_t       pc;
        rs_cfg_pkg::data_t       imm;
        rs_cfg_pkg::tag_t        rd;
        branch_op_pkg::op_kind_e kind;
        branch_op_pkg::br_cond_e cond;
        logic                    taken;
        logic                    hit;
        rs_cfg_pkg::tag_t        t1;
        rs_cfg_pkg::tag_t        t2;
        rs_cfg_pkg::data_t       d1;
        rs_cfg_pkg::data_t       d2;
        logic                    r1;
        logic                    r2;
        logic [2:0]              bus_v; // index 0 alu, 1 mul, 2 load
        rs_cfg_pkg::tag_t [2:0]  bus_t;
        rs_cfg_pkg::data_t [2:0] bus_d;
        logic                    fl;
    } op_rec_t;

    logic clk;
    logic reset;

    logic                    issue_valid;
    rs_cfg_pkg::data_t       issue_inst_num;
    rs_cfg_pkg::data_t       issue_pc;
    rs_cfg_pkg::data_t       issue_imm;
    rs_cfg_pkg::tag_t        issue_rd;
    branch_op_pkg::op_kind_e issue_kind;
    branch_op_pkg::br_cond_e issue_cond;
    logic                    issue_taken;
    logic                    issue_hit;
    rs_cfg_pkg::data_t       issue_op1;
    rs_cfg_pkg::data_t       issue_op2;

    op_rec_t steps [max_steps];
    string   names [max_steps];
    int      n_steps = 0;
    op_rec_t drv;
    op_rec_t q [$];    // entries the model holds, oldest first
    op_rec_t held;     // what the issue registers should show
    logic    exp_valid;
    integer  seed = 32'hdb5f_0ec2;
    int      errors = 0;
    int      test_start = 0;
    int      tests_run = 0;
    int      tests_failed = 0;
    string   cur_name = "";
    logic    table_done = 1'b0;

    tb_clock_gen u_clk (.clk(clk), .reset(reset));

    branch_rs_top #(.depth(depth)) uut (
        .clk(clk), .reset(reset), .flush(drv.fl), .dispatch(drv.disp),
        .inst_num(drv.inst), .pc(drv.pc), .rd(drv.rd), .kind(drv.kind), .cond(drv.cond),
        .imm(drv.imm), .pred_taken(drv.taken), .btb_hit(drv.hit),
        .src1_tag(drv.t1), .src2_tag(drv.t2), .src1_data(drv.d1), .src2_data(drv.d2),
        .src1_ready(drv.r1), .src2_ready(drv.r2),
        .alu_valid(drv.bus_v[0]), .alu_tag(drv.bus_t[0]), .alu_data(drv.bus_d[0]),
        .mul_valid(drv.bus_v[1]), .mul_tag(drv.bus_t[1]), .mul_data(drv.bus_d[1]),
        .load_valid(drv.bus_v[2]), .load_tag(drv.bus_t[2]), .load_data(drv.bus_d[2]),
        .issue_valid(issue_valid), .issue_inst_num(issue_inst_num), .issue_pc(issue_pc),
        .issue_imm(issue_imm), .issue_rd(issue_rd), .issue_kind(issue_kind),
        .issue_cond(issue_cond), .issue_taken(issue_taken), .issue_hit(issue_hit),
        .issue_op1(issue_op1), .issue_op2(issue_op2)
    );

    task automatic idle(input string name, input int n);
        op_rec_t s;
        for (int k = 0; k < n; k++) begin
            s = '0;
            s.inst = n_steps;
            s.pc = 32'h0000_4000 + 4 * n_steps;
            s.imm = $random(seed);
            s.rd = 8'h40 + n_steps[7:0];
            s.d1 = $random(seed);
            s.d2 = $random(seed);
            for (int b = 0; b < 3; b++) begin
                s.bus_d[b] = $random(seed);
            end
            steps[n_steps] = s;
            names[n_steps] = name;
            n_steps++;
        end
    endtask

    task automatic disp_step(input string name, input rs_cfg_pkg::tag_t t1, input logic r1,
                             input rs_cfg_pkg::tag_t t2, input logic r2,
                             input branch_op_pkg::op_kind_e kind,
                             input branch_op_pkg::br_cond_e cond,
                             input logic taken, input logic hit);
        idle(name, 1);
        steps[n_steps - 1].disp = 1'b1;
        steps[n_steps - 1].t1 = t1;
        steps[n_steps - 1].r1 = r1;
        steps[n_steps - 1].t2 = t2;
        steps[n_steps - 1].r2 = r2;
        steps[n_steps - 1].kind = kind;
        steps[n_steps - 1].cond = cond;
        steps[n_steps - 1].taken = taken;
        steps[n_steps - 1].hit = hit;
    endtask

    // puts a tag on a bus of the last step, valid or not
    task automatic add_bus(input int which, input rs_cfg_pkg::tag_t t, input logic v);
        steps[n_steps - 1].bus_t[which] = t;
        steps[n_steps - 1].bus_v[which] = v;
    endtask

    task automatic build_table();
        idle("reset_idle", 3);
        disp_step("in_order", 1, 1, 2, 1, br, c_eq, 1, 1);
        disp_step("in_order", 3, 1, 0, 1, jmp, c_eq, 1, 0);
        disp_step("in_order", 4, 1, 5, 1, br, c_ltu, 0, 1);
        disp_step("in_order", 6, 1, 7, 1, br, c_ge, 0, 0);
        idle("in_order", 3);
        disp_step("wake_alu", 10, 0, 2, 1, br, c_ne, 0, 1);
        idle("wake_alu", 1);
        add_bus(0, 10, 1);
        idle("wake_alu", 2);
        disp_step("wake_mul", 3, 1, 11, 0, br, c_lt, 1, 0);
        idle("wake_mul", 1);
        add_bus(1, 11, 1);
        idle("wake_mul", 2);
        disp_step("wake_load", 12, 0, 13, 0, br, c_geu, 1, 1);
        idle("wake_load", 1);
        add_bus(2, 12, 1);
        idle("wake_load", 1);
        add_bus(2, 13, 1);
        idle("wake_load", 2);
        disp_step("bus_priority", 14, 0, 15, 0, br, c_eq, 0, 0);
        idle("bus_priority", 1);
        add_bus(0, 14, 1);
        add_bus(1, 14, 1);
        add_bus(2, 14, 1);
        idle("bus_priority", 1);
        add_bus(1, 15, 1);
        add_bus(2, 15, 1);
        idle("bus_priority", 2);
        disp_step("dispatch_bypass", 20, 0, 21, 0, br, c_ne, 1, 1);
        add_bus(0, 20, 1);
        add_bus(2, 21, 1);
        disp_step("dispatch_bypass", 22, 0, 8, 1, jmp, c_eq, 0, 0);
        add_bus(1, 22, 1);
        idle("dispatch_bypass", 2);
        disp_step("bypass_no_valid", 23, 0, 9, 1, br, c_lt, 0, 1);
        add_bus(0, 23, 0); // tag present, strobe low
        idle("bypass_no_valid", 2);
        add_bus(0, 23, 1);
        idle("bypass_no_valid", 2);
        disp_step("older_first", 30, 0, 1, 1, br, c_ge, 1, 0);
        disp_step("older_first", 2, 1, 3, 1, jmp, c_eq, 1, 1);
        idle("older_first", 2);
        add_bus(1, 30, 1);
        idle("older_first", 3);
        disp_step("flush", 40, 0, 1, 1, br, c_eq, 0, 0);
        disp_step("flush", 2, 1, 3, 1, br, c_ne, 1, 1);
        disp_step("flush", 4, 1, 5, 1, jmp, c_eq, 0, 0);
        steps[n_steps - 1].fl = 1'b1; // dispatch in the flush cycle is dropped
        idle("flush", 1);
        add_bus(2, 40, 1);
        idle("flush", 2);
        disp_step("flush", 6, 1, 7, 1, br, c_ltu, 1, 0);
        idle("flush", 3);
    endtask

    // lowest index wins, alu over mul over load
    function automatic logic bus_match(input op_rec_t s, input rs_cfg_pkg::tag_t t,
                                       output rs_cfg_pkg::data_t d);
        bus_match = 1'b0;
        d = '0;
        for (int b = 2; b >= 0; b--) begin
            if (t != '0 && s.bus_v[b] && s.bus_t[b] == t) begin
                bus_match = 1'b1;
                d = s.bus_d[b];
            end
        end
    endfunction

    function automatic op_rec_t capture(input op_rec_t e, input op_rec_t s);
        rs_cfg_pkg::data_t d;
        op_rec_t r;
        r = e;
        if (!r.r1 && bus_match(s, r.t1, d)) begin
            r.r1 = 1'b1;
            r.d1 = d;
        end
        if (!r.r2 && bus_match(s, r.t2, d)) begin
            r.r2 = 1'b1;
            r.d2 = d;
        end
        return r;
    endfunction

    // what the coming edge does with this step's inputs
    task automatic predict(input op_rec_t s);
        exp_valid = 1'b0;
        if (s.fl) begin
            q.delete();
            held = '0;
        end else begin
            if (q.size() > 0 && q[0].r1 && q[0].r2) begin
                held = q.pop_front();
                exp_valid = 1'b1;
            end
            foreach (q[k]) begin
                q[k] = capture(q[k], s);
            end
            if (s.disp)
                q.push_back(capture(s, s));
        end
    endtask

    task automatic check_data(input string what, input rs_cfg_pkg::data_t exp,
                              input rs_cfg_pkg::data_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_tag(input string what, input rs_cfg_pkg::tag_t exp,
                             input rs_cfg_pkg::tag_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_kind(input string what, input branch_op_pkg::op_kind_e exp,
                              input branch_op_pkg::op_kind_e act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %s, actual %s", cur_name, what,
                     exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_cond(input string what, input branch_op_pkg::br_cond_e exp,
                              input branch_op_pkg::br_cond_e act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %s, actual %s", cur_name, what,
                     exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b, actual %b", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check_bit("issue_valid", exp_valid, issue_valid);
        check_data("inst_num", held.inst, issue_inst_num);
        check_data("pc", held.pc, issue_pc);
        check_data("imm", held.imm, issue_imm);
        check_data("op1", held.d1, issue_op1);
        check_data("op2", held.d2, issue_op2);
        check_tag("rd", held.rd, issue_rd);
        check_kind("kind", held.kind, issue_kind);
        check_cond("cond", held.cond, issue_cond);
        check_bit("taken", held.taken, issue_taken);
        check_bit("hit", held.hit, issue_hit);
    endtask

    initial begin
        drv = '0;
        held = '0;
        exp_valid = 1'b0;
        build_table();
        table_done = 1'b1;
        @(negedge reset);
        for (int i = 0; i < n_steps; i++) begin
            cur_name = names[i];
            drv = steps[i];   // 2 ns after the edge
            predict(steps[i]);
            @(posedge clk);
            #2;
            check_outputs();
            if (i == n_steps - 1 || names[i + 1] != names[i]) begin
                tests_run++;
                if (errors == test_start) begin
                    $display("test %-16s ok", cur_name);
                end else begin
                    tests_failed++;
                    $display("test %-16s %0d mismatches", cur_name, errors - test_start);
                end
                test_start = errors;
            end
        end
        drv = '0;
        $display("%0d tests run, %0d ok, %0d with errors, %0d mismatches in total",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // table length plus reset plus some slack
    initial begin
        wait (table_done);
        #((n_steps + 3 + 10) * 40);
        $display("timeout: run did not finish within %0d cycles", n_steps + 13);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // high through the first few rising edges, released just after one
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

// ==== branch_rs/branch_rs_top.sv ====
`timescale 1ns/1ps

module branch_rs_top #(
    parameter int depth = rs_cfg_pkg::default_depth
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    dispatch,
    input  rs_cfg_pkg::data_t       inst_num,
    input  rs_cfg_pkg::data_t       pc,
    input  rs_cfg_pkg::tag_t        rd,
    input  branch_op_pkg::op_kind_e kind,
    input  branch_op_pkg::br_cond_e cond,
    input  rs_cfg_pkg::data_t       imm,
    input  logic                    pred_taken,
    input  logic                    btb_hit,
    input  rs_cfg_pkg::tag_t        src1_tag,
    input  rs_cfg_pkg::tag_t        src2_tag,
    input  rs_cfg_pkg::data_t       src1_data,
    input  rs_cfg_pkg::data_t       src2_data,
    input  logic                    src1_ready,
    input  logic                    src2_ready,
    input  logic                    alu_valid,
    input  rs_cfg_pkg::tag_t        alu_tag,
    input  rs_cfg_pkg::data_t       alu_data,
    input  logic                    mul_valid,
    input  rs_cfg_pkg::tag_t        mul_tag,
    input  rs_cfg_pkg::data_t       mul_data,
    input  logic                    load_valid,
    input  rs_cfg_pkg::tag_t        load_tag,
    input  rs_cfg_pkg::data_t       load_data,
    output logic                    issue_valid,
    output rs_cfg_pkg::data_t       issue_inst_num,
    output rs_cfg_pkg::data_t       issue_pc,
    output rs_cfg_pkg::data_t       issue_imm,
    output rs_cfg_pkg::tag_t        issue_rd,
    output branch_op_pkg::op_kind_e issue_kind,
    output branch_op_pkg::br_cond_e issue_cond,
    output logic                    issue_taken,
    output logic                    issue_hit,
    output rs_cfg_pkg::data_t       issue_op1,
    output rs_cfg_pkg::data_t       issue_op2
);

    localparam int ptr_w = $clog2(depth);

    logic             wr_en;
    logic             issue_en;
    logic             clear_all;
    logic             head_ready;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;

    rs_cfg_pkg::data_t cap1_data;
    rs_cfg_pkg::data_t cap2_data;
    logic              cap1_ready;
    logic              cap2_ready;

    rs_control #(.depth(depth)) u_control (
        .clk(clk), .reset(reset), .flush(flush), .dispatch(dispatch),
        .head_ready(head_ready), .wr_en(wr_en), .issue_en(issue_en),
        .clear_all(clear_all), .wr_ptr(wr_ptr), .rd_ptr(rd_ptr)
    );

    rs_dispatch_bypass u_bypass (
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_data(src1_data), .src2_data(src2_data),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .alu_valid(alu_valid), .mul_valid(mul_valid), .load_valid(load_valid),
        .alu_tag(alu_tag), .mul_tag(mul_tag), .load_tag(load_tag),
        .alu_data(alu_data), .mul_data(mul_data), .load_data(load_data),
        .cap1_data(cap1_data), .cap2_data(cap2_data),
        .cap1_ready(cap1_ready), .cap2_ready(cap2_ready)
    );

    rs_operand_table #(.depth(depth)) u_operands (
        .clk(clk), .wr_en(wr_en), .issue_en(issue_en), .clear_all(clear_all),
        .wr_ptr(wr_ptr), .rd_ptr(rd_ptr),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .cap1_data(cap1_data), .cap2_data(cap2_data),
        .cap1_ready(cap1_ready), .cap2_ready(cap2_ready),
        .alu_valid(alu_valid), .mul_valid(mul_valid), .load_valid(load_valid),
        .alu_tag(alu_tag), .mul_tag(mul_tag), .load_tag(load_tag),
        .alu_data(alu_data), .mul_data(mul_data), .load_data(load_data),
        .head_ready(head_ready), .issue_op1(issue_op1), .issue_op2(issue_op2)
    );

    rs_payload_table #(.depth(depth)) u_payload (
        .clk(clk), .wr_en(wr_en), .issue_en(issue_en), .clear_all(clear_all),
        .wr_ptr(wr_ptr), .rd_ptr(rd_ptr),
        .inst_num(inst_num), .pc(pc), .imm(imm), .rd(rd),
        .kind(kind), .cond(cond), .pred_taken(pred_taken), .btb_hit(btb_hit),
        .issue_valid(issue_valid), .issue_inst_num(issue_inst_num),
        .issue_pc(issue_pc), .issue_imm(issue_imm), .issue_rd(issue_rd),
        .issue_kind(issue_kind), .issue_cond(issue_cond),
        .issue_taken(issue_taken), .issue_hit(issue_hit)
    );

endmodule

// ==== branch_rs/rs_payload_table.sv ====
`timescale 1ns/1ps

module rs_payload_table #(
    parameter int depth = rs_cfg_pkg::default_depth,
    localparam int ptr_w = $clog2(depth)
) (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic                    issue_en,
    input  logic                    clear_all,
    input  logic [ptr_w-1:0]        wr_ptr,
    input  logic [ptr_w-1:0]        rd_ptr,
    input  rs_cfg_pkg::data_t       inst_num,
    input  rs_cfg_pkg::data_t       pc,
    input  rs_cfg_pkg::data_t       imm,
    input  rs_cfg_pkg::tag_t        rd,
    input  branch_op_pkg::op_kind_e kind,
    input  branch_op_pkg::br_cond_e cond,
    input  logic                    pred_taken,
    input  logic                    btb_hit,
    output logic                    issue_valid,
    output rs_cfg_pkg::data_t       issue_inst_num,
    output rs_cfg_pkg::data_t       issue_pc,
    output rs_cfg_pkg::data_t       issue_imm,
    output rs_cfg_pkg::tag_t        issue_rd,
    output branch_op_pkg::op_kind_e issue_kind,
    output branch_op_pkg::br_cond_e issue_cond,
    output logic                    issue_taken,
    output logic                    issue_hit
);

    rs_cfg_pkg::data_t       inst_q  [depth];
    rs_cfg_pkg::data_t       pc_q    [depth];
    rs_cfg_pkg::data_t       imm_q   [depth];
    rs_cfg_pkg::tag_t        rd_q    [depth];
    branch_op_pkg::op_kind_e kind_q  [depth];
    branch_op_pkg::br_cond_e cond_q  [depth];
    logic [depth-1:0]        taken_q;
    logic [depth-1:0]        hit_q;

    // static fields, written once at dispatch
    always_ff @(posedge clk) begin
        if (wr_en) begin
            inst_q[wr_ptr]  <= inst_num;
            pc_q[wr_ptr]    <= pc;
            imm_q[wr_ptr]   <= imm;
            rd_q[wr_ptr]    <= rd;
            kind_q[wr_ptr]  <= kind;
            cond_q[wr_ptr]  <= cond;
            taken_q[wr_ptr] <= pred_taken;
            hit_q[wr_ptr]   <= btb_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (clear_all) begin
            issue_valid    <= 1'b0;
            issue_inst_num <= '0;
            issue_pc       <= '0;
            issue_imm      <= '0;
            issue_rd       <= '0;
            issue_kind     <= branch_op_pkg::op_none;
            issue_cond     <= branch_op_pkg::beq;
            issue_taken    <= 1'b0;
            issue_hit      <= 1'b0;
        end else begin
            issue_valid <= issue_en; // one-cycle pulse per record
            if (issue_en) begin
                issue_inst_num <= inst_q[rd_ptr];
                issue_pc       <= pc_q[rd_ptr];
                issue_imm      <= imm_q[rd_ptr];
                issue_rd       <= rd_q[rd_ptr];
                issue_kind     <= kind_q[rd_ptr];
                issue_cond     <= cond_q[rd_ptr];
                issue_taken    <= taken_q[rd_ptr];
                issue_hit      <= hit_q[rd_ptr];
            end
        end
    end

    // every dispatched op must be a real branch or jump
    a_kind_at_issue: assert property (
        @(posedge clk) disable iff (clear_all)
        issue_en |=> issue_kind != branch_op_pkg::op_none
    ) else $error("issued entry has kind op_none");

endmodule

// ==== branch_rs/rs_operand_table.sv ====
`timescale 1ns/1ps

module rs_operand_table #(
    parameter int depth = rs_cfg_pkg::default_depth,
    localparam int ptr_w = $clog2(depth)
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic              issue_en,
    input  logic              clear_all,
    input  logic [ptr_w-1:0]  wr_ptr,
    input  logic [ptr_w-1:0]  rd_ptr,
    input  rs_cfg_pkg::tag_t  src1_tag,
    input  rs_cfg_pkg::tag_t  src2_tag,
    input  rs_cfg_pkg::data_t cap1_data,
    input  rs_cfg_pkg::data_t cap2_data,
    input  logic              cap1_ready,
    input  logic              cap2_ready,
    input  logic              alu_valid,
    input  logic              mul_valid,
    input  logic              load_valid,
    input  rs_cfg_pkg::tag_t  alu_tag,
    input  rs_cfg_pkg::tag_t  mul_tag,
    input  rs_cfg_pkg::tag_t  load_tag,
    input  rs_cfg_pkg::data_t alu_data,
    input  rs_cfg_pkg::data_t mul_data,
    input  rs_cfg_pkg::data_t load_data,
    output logic              head_ready,
    output rs_cfg_pkg::data_t issue_op1,
    output rs_cfg_pkg::data_t issue_op2
);

    rs_cfg_pkg::tag_t  tag1 [depth];
    rs_cfg_pkg::tag_t  tag2 [depth];
    rs_cfg_pkg::data_t data1 [depth];
    rs_cfg_pkg::data_t data2 [depth];
    logic [depth-1:0]  rdy1;
    logic [depth-1:0]  rdy2;

    function automatic logic bus_hit(input rs_cfg_pkg::tag_t t);
        bus_hit = (t != '0) &&
                  ((alu_valid && alu_tag == t) ||
                   (mul_valid && mul_tag == t) ||
                   (load_valid && load_tag == t));
    endfunction

    function automatic rs_cfg_pkg::data_t bus_pick(input rs_cfg_pkg::tag_t t);
        if (alu_valid && alu_tag == t)
            bus_pick = alu_data;
        else if (mul_valid && mul_tag == t)
            bus_pick = mul_data;
        else
            bus_pick = load_data;
    endfunction

    // registered ready bits, so a wakeup at edge j issues at j+1
    assign head_ready = rdy1[rd_ptr] & rdy2[rd_ptr];

    always_ff @(posedge clk) begin
        if (clear_all) begin
            rdy1      <= '0;
            rdy2      <= '0;
            issue_op1 <= '0;
            issue_op2 <= '0;
        end else begin
            for (int i = 0; i < depth; i++) begin
                if (!rdy1[i] && bus_hit(tag1[i])) begin
                    rdy1[i]  <= 1'b1;
                    data1[i] <= bus_pick(tag1[i]);
                end
                if (!rdy2[i] && bus_hit(tag2[i])) begin
                    rdy2[i]  <= 1'b1;
                    data2[i] <= bus_pick(tag2[i]);
                end
            end
            if (issue_en) begin
                issue_op1    <= data1[rd_ptr];
                issue_op2    <= data2[rd_ptr];
                rdy1[rd_ptr] <= 1'b0; // free the slot
                rdy2[rd_ptr] <= 1'b0;
            end
            // new entry overrides anything above for its slot
            if (wr_en) begin
                tag1[wr_ptr]  <= src1_tag;
                tag2[wr_ptr]  <= src2_tag;
                data1[wr_ptr] <= cap1_data;
                data2[wr_ptr] <= cap2_data;
                rdy1[wr_ptr]  <= cap1_ready;
                rdy2[wr_ptr]  <= cap2_ready;
            end
        end
    end

    // an operand that became ready without a write was woken by a real tag
    for (genvar g = 0; g < depth; g++) begin : g_wake_chk
        a_wake_tag1: assert property (
            @(posedge clk)
            (!clear_all && !rdy1[g] && !(wr_en && wr_ptr == g)) ##1 rdy1[g]
            |-> tag1[g] != '0
        ) else $error("operand 1 of entry %0d woken with tag 0", g);

        a_wake_tag2: assert property (
            @(posedge clk)
            (!clear_all && !rdy2[g] && !(wr_en && wr_ptr == g)) ##1 rdy2[g]
            |-> tag2[g] != '0
        ) else $error("operand 2 of entry %0d woken with tag 0", g);
    end

endmodule

// ==== branch_rs/rs_dispatch_bypass.sv ====
`timescale 1ns/1ps

module rs_dispatch_bypass (
    input  rs_cfg_pkg::tag_t  src1_tag,
    input  rs_cfg_pkg::tag_t  src2_tag,
    input  rs_cfg_pkg::data_t src1_data,
    input  rs_cfg_pkg::data_t src2_data,
    input  logic              src1_ready,
    input  logic              src2_ready,
    input  logic              alu_valid,
    input  logic              mul_valid,
    input  logic              load_valid,
    input  rs_cfg_pkg::tag_t  alu_tag,
    input  rs_cfg_pkg::tag_t  mul_tag,
    input  rs_cfg_pkg::tag_t  load_tag,
    input  rs_cfg_pkg::data_t alu_data,
    input  rs_cfg_pkg::data_t mul_data,
    input  rs_cfg_pkg::data_t load_data,
    output rs_cfg_pkg::data_t cap1_data,
    output rs_cfg_pkg::data_t cap2_data,
    output logic              cap1_ready,
    output logic              cap2_ready
);

    // tag 0 is no register and never matches
    function automatic logic bus_hit(input rs_cfg_pkg::tag_t t);
        bus_hit = (t != '0) &&
                  ((alu_valid && alu_tag == t) ||
                   (mul_valid && mul_tag == t) ||
                   (load_valid && load_tag == t));
    endfunction

    // alu before mul before load
    function automatic rs_cfg_pkg::data_t bus_pick(input rs_cfg_pkg::tag_t t);
        if (alu_valid && alu_tag == t)
            bus_pick = alu_data;
        else if (mul_valid && mul_tag == t)
            bus_pick = mul_data;
        else
            bus_pick = load_data;
    endfunction

    always_comb begin
        cap1_ready = src1_ready;
        cap1_data  = src1_data;
        if (!src1_ready && bus_hit(src1_tag)) begin
            cap1_ready = 1'b1;
            cap1_data  = bus_pick(src1_tag);
        end
    end

    always_comb begin
        cap2_ready = src2_ready;
        cap2_data  = src2_data;
        if (!src2_ready && bus_hit(src2_tag)) begin
            cap2_ready = 1'b1;
            cap2_data  = bus_pick(src2_tag);
        end
    end

endmodule

// ==== branch_rs/rs_control.sv ====
`timescale 1ns/1ps

module rs_control #(
    parameter int depth = rs_cfg_pkg::default_depth,
    localparam int ptr_w = $clog2(depth)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             dispatch,
    input  logic             head_ready,
    output logic             wr_en,
    output logic             issue_en,
    output logic             clear_all,
    output logic [ptr_w-1:0] wr_ptr,
    output logic [ptr_w-1:0] rd_ptr
);

    logic [ptr_w:0] count; // one extra bit so full and empty differ
    logic empty;
    logic full;

    assign empty = (count == '0);
    assign full  = (int'(count) == depth);

    assign clear_all = reset | flush;

    // flush wins over dispatch and issue in the same cycle
    assign wr_en    = dispatch & ~flush & ~full;
    assign issue_en = ~empty & head_ready & ~flush;

    always_ff @(posedge clk) begin
        if (clear_all) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (issue_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, issue_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // dispatch source must respect occupancy
    a_no_dispatch_full: assert property (
        @(posedge clk) disable iff (reset)
        (dispatch && !flush) |-> !full
    ) else $error("dispatch into a full branch queue");

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        int'(count) <= depth
    ) else $error("occupancy count above depth");

    // pointers must agree with the count whenever an entry leaves
    a_issue_not_empty: assert property (
        @(posedge clk) disable iff (reset)
        issue_en |-> (wr_ptr != rd_ptr || full)
    ) else $error("issue from an empty queue");

endmodule

// ==== common/branch_op_pkg.sv ====
package branch_op_pkg;

    // what the branch unit does with the entry
    typedef enum logic [1:0] {
        op_none   = 2'd0,
        op_branch = 2'd1,
        op_jump   = 2'd2
    } op_kind_e;

    // risc-v funct3 encodings for conditional branches
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } br_cond_e;

endpackage

// ==== common/rs_cfg_pkg.sv ====
package rs_cfg_pkg;

    // datapath widths
    parameter int data_w = 32;
    parameter int tag_w  = 8;

    // pc, immediate, inst number and operand data share one word type
    typedef logic [data_w-1:0] data_t;

    // physical register tag, 0 means no register
    typedef logic [tag_w-1:0] tag_t;

    parameter int default_depth = 64; // power of two

endpackage
